// File: cache_sys.f
logic/cache_pkg.sv
logic/cache_req_decode.sv
logic/cache_word_ram.sv
logic/cache_way.sv
logic/cache_ctrl.sv
logic/cache_resp.sv
logic/cache_top.sv
sim/cache_tb_mem.sv
sim/cache_tb.sv

// File: logic/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl
    import cache_pkg::*;
#(
    parameter int INDEX_WIDTH  = 4,
    parameter int OFFSET_WIDTH = 3
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 start,
    input  cache_op_t                            op,
    input  logic [29-INDEX_WIDTH-OFFSET_WIDTH:0] tag,
    input  logic [INDEX_WIDTH-1:0]               index,
    input  logic                                 hit,
    input  logic                                 dirty,
    input  logic [29-INDEX_WIDTH-OFFSET_WIDTH:0] victim_tag,
    input  logic [(32 << OFFSET_WIDTH)-1:0]      line,
    output logic                                 word_we,
    output logic                                 fill_we,
    output logic [(32 << OFFSET_WIDTH)-1:0]      fill_line,
    output logic                                 mem_req,
    output logic                                 mem_write,
    output addr_t                                mem_addr,
    output logic [(32 << OFFSET_WIDTH)-1:0]      mem_wline,
    input  logic [(32 << OFFSET_WIDTH)-1:0]      mem_rline,
    input  logic                                 mem_ack,
    output logic                                 done,
    output logic                                 hit_first
);

    typedef enum logic [2:0] {
        idle,
        lookup,
        wb_req,
        wb_release,
        fill_req,
        fill_release,
        finish
    } state_t;

    state_t state;
    logic   missed;
    addr_t  wb_addr;
    addr_t  fill_addr;

    // Line base addresses with word and byte bits zero
    assign wb_addr   = {victim_tag, index, {OFFSET_WIDTH{1'b0}}, 2'b00};
    assign fill_addr = {tag, index, {OFFSET_WIDTH{1'b0}}, 2'b00};

    //////////////////////////////
    // Main FSM
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= idle;
            missed <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state  <= lookup;
                        missed <= 1'b0;
                    end
                end
                lookup: begin
                    if (hit) begin
                        state <= finish;
                    end else begin
                        missed <= 1'b1;
                        state  <= dirty ? wb_req : fill_req;
                    end
                end
                wb_req: begin
                    if (mem_ack) state <= wb_release;
                end
                wb_release: begin
                    if (!mem_ack) state <= fill_req;
                end
                fill_req: begin
                    if (mem_ack) state <= fill_release;
                end
                fill_release: begin
                    // second lookup is now a hit
                    if (!mem_ack) state <= lookup;
                end
                finish: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Memory request fields stay stable through each handshake
    always_ff @(posedge clk) begin
        if (state == lookup && !hit) begin
            mem_wline <= line;
            mem_addr  <= dirty ? wb_addr : fill_addr;
        end else if (state == wb_release && !mem_ack) begin
            mem_addr <= fill_addr;
        end
    end

    assign mem_req   = (state == wb_req) || (state == fill_req);
    assign mem_write = (state == wb_req) || (state == wb_release);

    // Way write strobes
    assign word_we   = (state == lookup) && hit && (op == op_write);
    assign fill_we   = (state == fill_req) && mem_ack;
    assign fill_line = mem_rline;

    assign done      = (state == finish);
    assign hit_first = !missed;

    // Request and address held until the memory acks
    assert property (@(posedge clk) disable iff (reset)
        (mem_req && !mem_ack) |=> (mem_req && $stable(mem_addr)))
        else $error("memory request changed before mem_ack");

endmodule

// File: logic/cache_pkg.sv
package cache_pkg;

    ////////////////////////////////
    // CPU side data types
    ////////////////////////////////

    // One data word on the CPU port
    typedef logic [31:0] word_t;

    // Byte write mask, bit n enables byte n
    typedef logic [3:0] byte_en_t;

    // Byte address, low two bits are always zero
    typedef logic [31:0] addr_t;

    // Kind of the captured CPU request
    typedef enum logic {
        op_read,
        op_write
    } cache_op_t;

    ////////////////////////////////
    // Statistics
    ////////////////////////////////

    // Hit and miss event counter
    typedef logic [15:0] count_t;

endpackage

// File: logic/cache_req_decode.sv
`timescale 1ns/1ps

module cache_req_decode
    import cache_pkg::*;
#(
    parameter int INDEX_WIDTH  = 4,
    parameter int OFFSET_WIDTH = 3
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cpu_req,
    input  logic                     cpu_write,
    input  addr_t                    cpu_addr,
    input  byte_en_t                 cpu_byte_en,
    input  word_t                    cpu_wdata,
    input  logic                     resp_idle,
    output logic                     start,
    output cache_op_t                op,
    output logic [29-INDEX_WIDTH-OFFSET_WIDTH:0] tag,
    output logic [INDEX_WIDTH-1:0]   index,
    output logic [OFFSET_WIDTH-1:0]  word_sel,
    output byte_en_t                 byte_en,
    output word_t                    wdata
);

    localparam int TAG_WIDTH = 30 - INDEX_WIDTH - OFFSET_WIDTH;

    logic busy;
    logic capture;

    // A new request is taken when nothing is in flight, or when the
    // previous one has been fully released
    assign capture = cpu_req && (!busy || resp_idle);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            start <= 1'b0;
        end else begin
            start <= capture;
            if (capture) begin
                busy <= 1'b1;
            end else if (resp_idle && !cpu_req) begin
                busy <= 1'b0;
            end
        end
    end

    // Request fields, held until the next capture
    always_ff @(posedge clk) begin
        if (capture) begin
            op       <= cpu_write ? op_write : op_read;
            tag      <= cpu_addr[31 -: TAG_WIDTH];
            index    <= cpu_addr[2 + OFFSET_WIDTH +: INDEX_WIDTH];
            word_sel <= cpu_addr[2 +: OFFSET_WIDTH];
            // reads see the whole word
            byte_en  <= cpu_write ? cpu_byte_en : '1;
            wdata    <= cpu_wdata;
        end
    end

    // CPU only issues word aligned accesses
    assert property (@(posedge clk) disable iff (reset)
        cpu_req |-> (cpu_addr[1:0] == 2'b00))
        else $error("unaligned CPU address %h", cpu_addr);

endmodule

// File: logic/cache_resp.sv
`timescale 1ns/1ps

module cache_resp
    import cache_pkg::*;
#(
    parameter int OFFSET_WIDTH = 3
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            done,
    input  logic                            hit_first,
    input  logic                            op_write,
    input  logic [OFFSET_WIDTH-1:0]         word_sel,
    input  logic [(32 << OFFSET_WIDTH)-1:0] line,
    input  logic                            cpu_req,
    output word_t                           cpu_rdata,
    output logic                            cpu_ack,
    output logic                            resp_idle,
    output count_t                          hit_count,
    output count_t                          miss_count
);

    logic release_seen;

    // CPU has dropped its request while ack is up
    assign release_seen = cpu_ack && !cpu_req;

    always_ff @(posedge clk) begin
        if (reset) begin
            cpu_ack    <= 1'b0;
            resp_idle  <= 1'b1;
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            if (done) begin
                cpu_ack <= 1'b1;
                if (hit_first) hit_count <= hit_count + 1'b1;
                else miss_count <= miss_count + 1'b1;
            end else if (release_seen) begin
                cpu_ack <= 1'b0;
            end

            // Idle from the ack drop until the next request is seen
            if (release_seen) resp_idle <= 1'b1;
            else if (cpu_req) resp_idle <= 1'b0;
        end
    end

    // Read data, word picked out of the current line
    always_ff @(posedge clk) begin
        if (done && !op_write) begin
            cpu_rdata <= line[32*word_sel +: 32];
        end
    end

endmodule

// File: logic/cache_top.sv
`timescale 1ns/1ps

module cache_top
    import cache_pkg::*;
#(
    parameter int INDEX_WIDTH  = 4,
    parameter int OFFSET_WIDTH = 3
) (
    input  logic                            clk,
    input  logic                            reset,
    // CPU port
    input  logic                            cpu_req,
    input  logic                            cpu_write,
    input  addr_t                           cpu_addr,
    input  byte_en_t                        cpu_byte_en,
    input  word_t                           cpu_wdata,
    output word_t                           cpu_rdata,
    output logic                            cpu_ack,
    // Memory port
    output logic                            mem_req,
    output logic                            mem_write,
    output addr_t                           mem_addr,
    output logic [(32 << OFFSET_WIDTH)-1:0] mem_wline,
    input  logic [(32 << OFFSET_WIDTH)-1:0] mem_rline,
    input  logic                            mem_ack,
    // Statistics
    output count_t                          hit_count,
    output count_t                          miss_count
);

    localparam int TAG_WIDTH  = 30 - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int LINE_WIDTH = 32 << OFFSET_WIDTH;

    // Decoded request
    logic                    start;
    cache_op_t               op;
    logic [TAG_WIDTH-1:0]    tag;
    logic [INDEX_WIDTH-1:0]  index;
    logic [OFFSET_WIDTH-1:0] word_sel;
    byte_en_t                byte_en;
    word_t                   wdata;

    // Way status and line data
    logic                    hit;
    logic                    dirty;
    logic [TAG_WIDTH-1:0]    victim_tag;
    logic [LINE_WIDTH-1:0]   line;
    logic [LINE_WIDTH-1:0]   fill_line;
    logic                    word_we;
    logic                    fill_we;

    // Completion
    logic                    done;
    logic                    hit_first;
    logic                    resp_idle;

    cache_req_decode #(
        .INDEX_WIDTH  (INDEX_WIDTH),
        .OFFSET_WIDTH (OFFSET_WIDTH)
    ) i_req_decode (.*);

    cache_way #(
        .INDEX_WIDTH  (INDEX_WIDTH),
        .OFFSET_WIDTH (OFFSET_WIDTH)
    ) i_way (.*);

    cache_ctrl #(
        .INDEX_WIDTH  (INDEX_WIDTH),
        .OFFSET_WIDTH (OFFSET_WIDTH)
    ) i_ctrl (.*);

    cache_resp #(
        .OFFSET_WIDTH (OFFSET_WIDTH)
    ) i_resp (
        .op_write (op == op_write),
        .*
    );

endmodule

// File: logic/cache_way.sv
`timescale 1ns/1ps

module cache_way
    import cache_pkg::*;
#(
    parameter int INDEX_WIDTH  = 4,
    parameter int OFFSET_WIDTH = 3
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [INDEX_WIDTH-1:0]               index,
    input  logic [29-INDEX_WIDTH-OFFSET_WIDTH:0] tag,
    input  logic [OFFSET_WIDTH-1:0]              word_sel,
    input  byte_en_t                             byte_en,
    input  word_t                                wdata,
    input  logic                                 word_we,
    input  logic                                 fill_we,
    input  logic [(32 << OFFSET_WIDTH)-1:0]      fill_line,
    output logic                                 hit,
    output logic                                 dirty,
    output logic [29-INDEX_WIDTH-OFFSET_WIDTH:0] victim_tag,
    output logic [(32 << OFFSET_WIDTH)-1:0]      line
);

    localparam int TAG_WIDTH = 30 - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int DEPTH     = 1 << INDEX_WIDTH;
    localparam int WORDS     = 1 << OFFSET_WIDTH;

    logic [TAG_WIDTH-1:0] tag_mem [DEPTH];
    logic [DEPTH-1:0]     valid_bits;
    logic [DEPTH-1:0]     dirty_bits;
    byte_en_t             col_mask;

    //////////////////////////////
    // Line state
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (fill_we) begin
            valid_bits[index] <= 1'b1;
        end
    end

    // Dirty is only looked at together with valid
    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_mem[index]    <= tag;
            dirty_bits[index] <= 1'b0;
        end else if (word_we) begin
            dirty_bits[index] <= 1'b1;
        end
    end

    assign victim_tag = tag_mem[index];
    assign hit        = valid_bits[index] && (tag_mem[index] == tag);
    assign dirty      = valid_bits[index] && dirty_bits[index];

    //////////////////////////////
    // Word columns
    //////////////////////////////

    // refill always writes whole words
    assign col_mask = fill_we ? '1 : byte_en;

    for (genvar g = 0; g < WORDS; g++) begin : g_col
        logic  col_we;
        word_t col_wdata;

        assign col_we    = fill_we || (word_we && (word_sel == OFFSET_WIDTH'(g)));
        assign col_wdata = fill_we ? fill_line[32*g +: 32] : wdata;

        cache_word_ram #(
            .INDEX_WIDTH (INDEX_WIDTH)
        ) i_word_ram (
            .clk     (clk),
            .we      (col_we),
            .byte_en (col_mask),
            .addr    (index),
            .wdata   (col_wdata),
            .rdata   (line[32*g +: 32])
        );
    end

    // Controller never writes a word and a line at once,
    // and a word write needs a matching line
    assert property (@(posedge clk) disable iff (reset)
        !(word_we && fill_we))
        else $error("word write and line fill in the same cycle");

    assert property (@(posedge clk) disable iff (reset)
        word_we |-> hit)
        else $error("word write without a hit");

endmodule

// File: logic/cache_word_ram.sv
`timescale 1ns/1ps

module cache_word_ram
    import cache_pkg::*;
#(
    parameter int INDEX_WIDTH = 4
) (
    input  logic                   clk,
    input  logic                   we,
    input  byte_en_t               byte_en,
    input  logic [INDEX_WIDTH-1:0] addr,
    input  word_t                  wdata,
    output word_t                  rdata
);

    localparam int DEPTH = 1 << INDEX_WIDTH;

    word_t mem [DEPTH];

    // One byte lane per mask bit
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // Asynchronous read for single cycle lookup
    assign rdata = mem[addr];

endmodule

// File: sim/cache_cases.txt
# op(R/W) address byte_mask write_data expected_read_data expected_hit
# expected_read_data is ignored for writes
R 00000100 f 00000000 fffffeff 0
R 00000104 f 00000000 fffffefb 1
R 00000100 f 00000000 fffffeff 1
W 00000108 3 12345678 00000000 1
R 00000108 f 00000000 ffff5678 1
W 0000010c a aabbccdd 00000000 1
R 0000010c f 00000000 aaffccf3 1
R 00000300 f 00000000 fffffcff 0
R 00000108 f 00000000 ffff5678 0
R 0000010c f 00000000 aaffccf3 1
R 0000011c f 00000000 fffffee3 1
W 00001040 f cafef00d 00000000 0
R 00001040 f 00000000 cafef00d 1
R 00001044 f 00000000 ffffefbb 1
R 0000105c f 00000000 ffffefa3 1
W 00002044 4 00990000 00000000 0
R 00002044 f 00000000 ff99dfbb 1
R 00001040 f 00000000 cafef00d 0
R 00002044 f 00000000 ff99dfbb 0
R 00001044 f 00000000 ffffefbb 0
R ffffffe0 f 00000000 0000001f 0
W fffffffc f 01020304 00000000 1
R fffffffc f 00000000 01020304 1
R 000001e0 f 00000000 fffffe1f 0
R fffffffc f 00000000 01020304 0

// File: sim/cache_tb.sv
`timescale 1ns/1ps

module cache_tb
    import cache_pkg::*;
();

    localparam int          INDEX_WIDTH  = 4;
    localparam int          OFFSET_WIDTH = 3;
    localparam int          LINE_WIDTH   = 32 << OFFSET_WIDTH;
    localparam int          CLK_PERIOD   = 40;
    localparam int unsigned SEED         = 32'hae37_9be0;
    localparam              CASE_FILE    = "sim/cache_cases.txt";

    logic                  clk;
    logic                  reset;
    logic                  cpu_req;
    logic                  cpu_write;
    addr_t                 cpu_addr;
    byte_en_t              cpu_byte_en;
    word_t                 cpu_wdata;
    word_t                 cpu_rdata;
    logic                  cpu_ack;
    logic                  mem_req;
    logic                  mem_write;
    addr_t                 mem_addr;
    logic [LINE_WIDTH-1:0] mem_wline;
    logic [LINE_WIDTH-1:0] mem_rline;
    logic                  mem_ack;
    count_t                hit_count;
    count_t                miss_count;

    // One entry per CPU access from the case file
    bit       case_write [$];
    addr_t    case_addr  [$];
    byte_en_t case_mask  [$];
    word_t    case_wdata [$];
    word_t    case_rdata [$];
    bit       case_hit   [$];
    int       num_cases = 0;
    int       hit_total = 0;
    int       miss_total = 0;

    // Expected counter values after the accesses run so far
    int       exp_hits = 0;
    int       exp_misses = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cache_top #(
        .INDEX_WIDTH  (INDEX_WIDTH),
        .OFFSET_WIDTH (OFFSET_WIDTH)
    ) i_cache_top (.*);

    cache_tb_mem #(
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .SEED         (SEED)
    ) i_mem (.*);

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    //////////////////////////////
    // Case file reader
    //////////////////////////////

    task automatic load_cases();
        int          fd;
        int          c;
        int          n;
        logic [31:0] addr;
        logic [31:0] mask;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [31:0] hit;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the case file %s", CASE_FILE);
            $display("test failed");
            $fatal(1);
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == "#") begin
                    while (c != "\n" && c != -1) c = $fgetc(fd);
                end else if (c == "R" || c == "W") begin
                    n = $fscanf(fd, "%h %h %h %h %h", addr, mask, wdata, rdata, hit);
                    if (n != 5) begin
                        $display("case line %0d in %s is malformed", num_cases + 1, CASE_FILE);
                        $display("test failed");
                        $fatal(1);
                    end else begin
                        case_write.push_back(c == "W");
                        case_addr.push_back(addr);
                        case_mask.push_back(mask[3:0]);
                        case_wdata.push_back(wdata);
                        case_rdata.push_back(rdata);
                        case_hit.push_back(hit != 0);
                        if (hit != 0) hit_total++;
                        else miss_total++;
                        num_cases++;
                    end
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
    endtask

    // One full four-phase CPU access with its checks
    task automatic run_access(input int i);
        int edges;
        @(negedge clk);
        cpu_req     = 1'b1;
        cpu_write   = case_write[i];
        cpu_addr    = case_addr[i];
        cpu_byte_en = case_mask[i];
        cpu_wdata   = case_wdata[i];
        edges       = 0;
        while (!cpu_ack) begin
            @(negedge clk);
            edges++;
        end
        // Hit ack comes three edges after the edge that samples the request
        if (case_hit[i]) check_value("cpu_ack latency", 3, edges - 1);
        if (!case_write[i]) check_value("cpu_rdata", case_rdata[i], cpu_rdata);
        if (case_hit[i]) begin
            exp_hits++;
        end else begin
            exp_misses++;
        end
        check_value("hit_count", exp_hits, hit_count);
        check_value("miss_count", exp_misses, miss_count);
        // Ack must stay up while a slow CPU holds req
        repeat (i % 3) begin
            @(negedge clk);
            check_value("cpu_ack", 1, cpu_ack);
        end
        cpu_req = 1'b0;
        @(negedge clk);
        check_value("cpu_ack", 0, cpu_ack);
    endtask

    //////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        cpu_req     = 1'b0;
        cpu_write   = 1'b0;
        cpu_addr    = '0;
        cpu_byte_en = '0;
        cpu_wdata   = '0;
        load_cases();
        if (num_cases == 0) begin
            $display("no cases found in %s", CASE_FILE);
            $display("test failed");
            $fatal(1);
        end else begin
            repeat (5) @(negedge clk);
            reset = 1'b0;
            check_value("cpu_ack", 0, cpu_ack);
            check_value("hit_count", 0, hit_count);
            check_value("miss_count", 0, miss_count);
            for (int i = 0; i < num_cases; i++) begin
                run_access(i);
            end
            check_value("hit_count", hit_total, hit_count);
            check_value("miss_count", miss_total, miss_count);
            $display("test passed");
            $finish;
        end
    end

    initial begin
        wait (num_cases > 0);
        #(num_cases * 200 * CLK_PERIOD);
        $display("timeout, the accesses did not complete within %0d clock periods",
                 num_cases * 200);
        $display("test failed");
        $fatal(1);
    end

endmodule

// File: sim/cache_tb_mem.sv
`timescale 1ns/1ps

module cache_tb_mem
    import cache_pkg::*;
#(
    parameter int          OFFSET_WIDTH = 3,
    parameter int unsigned SEED         = 32'h0
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            mem_req,
    input  logic                            mem_write,
    input  addr_t                           mem_addr,
    input  logic [(32 << OFFSET_WIDTH)-1:0] mem_wline,
    output logic [(32 << OFFSET_WIDTH)-1:0] mem_rline,
    output logic                            mem_ack
);

    localparam int WORDS = 1 << OFFSET_WIDTH;

    // Words written back so far, all others still hold their start value
    addr_t       written_addr [$];
    word_t       written_data [$];
    int unsigned seed;
    int unsigned wait_cycles;
    int          k;

    // Start value of every word is its own address inverted
    function automatic word_t read_word(input addr_t addr);
        word_t value;
        value = ~addr;
        foreach (written_addr[i]) begin
            if (written_addr[i] == addr) value = written_data[i];
        end
        return value;
    endfunction

    task automatic write_word(input addr_t addr, input word_t data);
        int found;
        found = -1;
        foreach (written_addr[i]) begin
            if (written_addr[i] == addr) found = i;
        end
        if (found < 0) begin
            written_addr.push_back(addr);
            written_data.push_back(data);
        end else begin
            written_data[found] = data;
        end
    endtask

    //////////////////////////////
    // Memory handshake responder
    //////////////////////////////

    initial begin
        seed        = SEED;
        wait_cycles = $urandom(seed);
        mem_ack     = 1'b0;
        mem_rline   = '0;
        forever begin
            @(negedge clk);
            if (!reset && mem_req) begin
                // Random response delay of 0 to 3 cycles
                wait_cycles = $urandom % 4;
                repeat (wait_cycles) @(negedge clk);
                for (k = 0; k < WORDS; k++) begin
                    if (mem_write) begin
                        write_word(mem_addr + 32'(4 * k), mem_wline[32*k +: 32]);
                    end else begin
                        mem_rline[32*k +: 32] = read_word(mem_addr + 32'(4 * k));
                    end
                end
                mem_ack = 1'b1;
                // Hold ack until the cache releases its request
                @(negedge clk);
                while (mem_req) @(negedge clk);
                mem_ack = 1'b0;
            end
        end
    end

endmodule
